// File: sim.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/mem_req_port.sv
hdl/store_align.sv
hdl/ram_core.sv
hdl/load_extend.sv
hdl/mem_subsystem.sv
bench/mem_tb.sv

// File: Makefile
# Verilator build and run for the memory subsystem testbench

TOP = mem_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// File: bench/mem_tb.sv
// Memory subsystem testbench
// Random traffic on the data and fetch ports against a byte model
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module mem_tb;
    import mem_pkg::*;

    localparam int AW         = $clog2(`MEM_BYTES);
    localparam int N_ACCESS   = 100;                          // Upper bound on accesses run
    localparam int TIMEOUT_NS = (N_ACCESS * 12 + 50) * 8;     // 12 cycles each plus margin
    localparam logic [31:0] WORD_MASK = 32'(`MEM_BYTES - 4);  // Aligned and inside the RAM

    logic        clock, rst, req, ack, err;
    mem_op_e     op;
    logic [31:0] addr, wdata, rdata, fetch_addr, instr;
    logic [7:0]  model [0:`MEM_BYTES-1];   // Little-endian reference bytes
    logic [31:0] seed = 32'hbaa7d2f1;
    logic [31:0] base;                     // Word under test
    int          errors = 0;
    int          n_access = 0;

    mem_subsystem DUT (
        .clock, .rst, .req, .op, .addr, .wdata, .ack, .rdata, .err, .fetch_addr, .instr
    );

    always #4 clock = ~clock;   // 8 ns period

    // Master holding req keeps ack up and the response frozen
    assert property (@(posedge clock) disable iff (!rst)
        (ack && req) |=> (ack && $stable(rdata) && $stable(err)))
        else begin
            errors++;
            $display("Response changed or ack fell while req was held high");
        end

    function automatic logic [31:0] next_rand();   // xorshift32
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    // Expected load data from the byte model and zero for stores
    function automatic logic [31:0] load_value(input mem_op_e kind, input logic [31:0] a);
        logic [AW-1:0] o;
        logic [15:0]   h;
        o = AW'(a - `MEM_BASE);
        h = {model[o + 1'b1], model[o]};
        case (kind)
            LB:      return {{24{model[o][7]}}, model[o]};
            LBU:     return {24'h0, model[o]};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'h0, h};
            LW:      return {model[o + 2'd3], model[o + 2'd2], h};
            default: return 32'h0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Two cycles of reset, then ack and instr must read zero
    task automatic reset_dut();
        rst = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        rst = 1'b1;
        req = 1'b0;
        check_value("ack", {31'h0, ack}, 32'h0);
        check_value("instr", instr, 32'h0);
    endtask

    // One four-phase access with the store applied to the model first
    task automatic access(input mem_op_e kind, input logic [31:0] a, input logic [31:0] d);
        logic [AW-1:0] o;
        logic          bad;
        logic [31:0]   exp;
        int            edges;
        int            hold;
        o   = AW'(a - `MEM_BASE);
        bad = ((a - `MEM_BASE) >= 32'(`MEM_BYTES)) || a[31]
            || (kind inside {LH, LHU, SH} && o[0]) || (kind inside {LW, SW} && o[1:0] != 2'b00);
        exp = bad ? 32'h0 : load_value(kind, a);
        if (!bad && kind inside {SB, SH, SW}) begin   // Only the lanes the store covers
            model[o] = d[7:0];
            if (kind != SB) model[o + 1'b1] = d[15:8];
            if (kind == SW) model[o + 2'd2] = d[23:16];
            if (kind == SW) model[o + 2'd3] = d[31:24];
        end
        n_access++;
        req   = 1'b1;
        op    = kind;
        addr  = a;
        wdata = d;
        edges = 0;
        while (!ack && edges < 16) begin   // Edge 0 accepts and ack is seen after edge 4
            @(posedge clock);
            #1;
            edges++;
        end
        check_value("edges to ack", edges, 5);
        check_value("rdata", rdata, exp);
        check_value("err", {31'h0, err}, {31'h0, bad});
        hold = next_rand() % 3;   // Req stays up a while as back-pressure
        #(hold * 8);
        req = 1'b0;
        @(posedge clock);
        #1;
        check_value("ack", {31'h0, ack}, 32'h0);   // Falls at the edge that sees req low
    endtask

    initial begin
        clock      = 1'b0;
        rst        = 1'b0;
        req        = 1'b0;
        op         = LW;
        addr       = 32'h0;
        wdata      = 32'h0;
        fetch_addr = 32'h0;
        reset_dut();
        for (int n = 0; n < 8; n++) begin   // Word round trip
            base = next_rand() & WORD_MASK;
            access(SW, base, next_rand());
            access(LW, base, 32'h0);
        end
        for (int n = 0; n < 4; n++) begin   // Lane merging at every offset
            base = next_rand() & WORD_MASK;
            access(SW, base, next_rand());
            for (int k = 0; k < 4; k++) access(SB, base + k, next_rand());
            access(LW, base, 32'h0);
            access(SH, base, next_rand());
            access(SH, base + 2, next_rand());
            access(LW, base, 32'h0);
        end
        for (int n = 0; n < 2; n++) begin   // Extension with lane top bits set and then clear
            base = next_rand() & WORD_MASK;
            access(SW, base, n == 0 ? next_rand() | 32'h8080_8080 : next_rand() & 32'h7f7f_7f7f);
            for (int k = 0; k < 4; k++) begin
                access(LB, base + k, 32'h0);
                access(LBU, base + k, 32'h0);
                if (k[0] == 1'b0) begin
                    access(LH, base + k, 32'h0);
                    access(LHU, base + k, 32'h0);
                end
            end
        end
        base = next_rand() & WORD_MASK;   // Rejected accesses leave the word alone
        access(SW, base, next_rand());
        access(SW, base + `MEM_BYTES, next_rand());   // Aliases base if not blocked
        access(SW, base | 32'h8000_0000, next_rand());
        access(SH, base + 1, next_rand());
        access(SW, base + 2, next_rand());
        access(LH, base + 3, 32'h0);
        access(LW, base + 1, 32'h0);
        access(LB, base + `MEM_BYTES, 32'h0);
        access(LW, base, 32'h0);
        for (int n = 0; n < 4; n++) begin   // Fetch ignores low bits and wraps
            base = next_rand() & WORD_MASK;
            access(SW, base, next_rand());
            fetch_addr = base + (next_rand() & 32'h3) + (n[0] ? 32'(`MEM_BYTES) : 32'h0);
            @(posedge clock);
            #1;
            check_value("instr", instr, load_value(LW, base));
        end
        req  = 1'b1;   // Reset arrives while a response is held
        op   = LW;
        addr = base;
        while (!ack) begin
            @(posedge clock);
            #1;
        end
        reset_dut();
        $display("%0d accesses, %0d errors", n_access, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout, run still going after %0d ns", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/mem_subsystem.sv
// Memory subsystem top
// Data port pipeline (capture, align, RAM, extend) and instruction fetch
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem (
    input  wire                   clock,
    input  wire                   rst,
    input  wire                   req,
    input  wire mem_pkg::mem_op_e op,
    input  wire [31:0]            addr,
    input  wire [31:0]            wdata,
    output logic                  ack,
    output logic [31:0]           rdata,
    output logic                  err,
    input  wire [31:0]            fetch_addr,
    output logic [31:0]           instr
);
    import mem_pkg::*;

    logic      req_valid;   // Capture to align
    mem_req_t  req_q;
    logic      cmd_valid;   // Align to RAM
    ram_cmd_t  cmd;
    logic      rd_valid;    // RAM to extend
    mem_word_u rd_word;
    mem_op_e   rd_op;
    logic [1:0] rd_offset;
    logic      rd_err;
    logic      rsp_valid;   // Extend back to the port
    mem_rsp_t  rsp;

    mem_req_port u_port (
        .clock, .rst, .req, .op, .addr, .wdata, .ack, .rdata, .err,
        .req_valid, .req_out(req_q), .rsp_valid, .rsp_in(rsp)
    );

    store_align u_align (
        .clock, .rst, .in_valid(req_valid), .req_in(req_q), .cmd_valid, .cmd
    );

    ram_core u_ram (
        .clock, .rst, .cmd_valid, .cmd, .rd_valid, .rd_word, .rd_op,
        .rd_offset, .rd_err, .fetch_addr, .instr
    );

    load_extend u_ext (
        .clock, .rst, .in_valid(rd_valid), .word(rd_word), .op(rd_op),
        .offset(rd_offset), .err(rd_err), .rsp_valid, .rsp
    );

endmodule

`default_nettype wire

// File: hdl/load_extend.sv
// Load extension stage
// Picks the addressed byte or halfword and sign or zero extends it
`timescale 1ns/1ns
`default_nettype none

module load_extend (
    input  wire                     clock,
    input  wire                     rst,
    input  wire                     in_valid,
    input  wire mem_pkg::mem_word_u word,
    input  wire mem_pkg::mem_op_e   op,
    input  wire [1:0]               offset,
    input  wire                     err,
    output logic                    rsp_valid,
    output mem_pkg::mem_rsp_t       rsp
);
    import mem_pkg::*;

    logic [7:0]  sel_b;
    logic [15:0] sel_h;
    logic [31:0] ext;

    assign sel_b = word.lane[offset];
    assign sel_h = offset[1] ? {word.lane[3], word.lane[2]} : {word.lane[1], word.lane[0]};

    always_comb begin
        case (op)
            LB:      ext = {{24{sel_b[7]}}, sel_b};
            LBU:     ext = {24'b0, sel_b};
            LH:      ext = {{16{sel_h[15]}}, sel_h};
            LHU:     ext = {16'b0, sel_h};
            LW:      ext = word.word;
            default: ext = '0;   // Stores return zero
        endcase
        if (err) ext = '0;
    end

    always_ff @(posedge clock) begin
        if (!rst) rsp_valid <= 1'b0;
        else      rsp_valid <= in_valid;
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            rsp.rdata <= ext;
            rsp.err   <= err;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ram_core.sv
// Byte-lane RAM
// Data access stage with lane writes, plus a registered fetch port
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module ram_core (
    input  wire                     clock,
    input  wire                     rst,
    input  wire                     cmd_valid,
    input  wire mem_pkg::ram_cmd_t  cmd,
    output logic                    rd_valid,
    output mem_pkg::mem_word_u      rd_word,
    output mem_pkg::mem_op_e        rd_op,
    output logic [1:0]              rd_offset,
    output logic                    rd_err,
    input  wire [31:0]              fetch_addr,
    output logic [31:0]             instr
);
    import mem_pkg::*;

    mem_word_u mem [0:`MEM_BYTES/4-1];   // Four lanes per word

    logic [31:0]           fetch_offs;
    logic [`MEM_IDX_W-1:0] fetch_idx;

    assign fetch_offs = fetch_addr - `MEM_BASE;
    assign fetch_idx  = fetch_offs[`MEM_IDX_W+1:2];   // Wraps inside RAM

    // Lane writes, disabled lanes keep their byte
    always_ff @(posedge clock) begin
        if (cmd_valid) begin
            for (int i = 0; i < 4; i++) begin
                if (cmd.be[i]) mem[cmd.idx].lane[i] <= cmd.wdata.lane[i];
            end
        end
    end

    // Load read and sideband carried to the extend stage
    always_ff @(posedge clock) begin
        if (cmd_valid) begin
            if (cmd.rd) rd_word <= mem[cmd.idx];
            rd_op     <= cmd.op;
            rd_offset <= cmd.offset;
            rd_err    <= cmd.err;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst) rd_valid <= 1'b0;
        else      rd_valid <= cmd_valid;
    end

    // Fetch port, one cycle latency
    always_ff @(posedge clock) begin
        if (!rst) instr <= '0;
        else      instr <= mem[fetch_idx].word;
    end

endmodule

`default_nettype wire

// File: hdl/store_align.sv
// Address check and lane steering stage
// Flags range and alignment errors, builds byte enables and lane data
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module store_align (
    input  wire                     clock,
    input  wire                     rst,
    input  wire                     in_valid,
    input  wire mem_pkg::mem_req_t  req_in,
    output logic                    cmd_valid,
    output mem_pkg::ram_cmd_t       cmd
);
    import mem_pkg::*;

    logic [31:0] offs;      // Byte offset from RAM base
    logic [1:0]  boff;      // Byte within the word
    logic        is_store;
    logic        misalign;
    logic        bad;
    logic [3:0]  be_raw;    // Lanes before the error mask
    mem_word_u   steer;

    assign offs     = req_in.addr - `MEM_BASE;
    assign boff     = offs[1:0];
    assign is_store = req_in.op inside {SB, SH, SW};

    always_comb begin
        be_raw     = 4'b0000;
        misalign   = 1'b0;
        steer.word = req_in.wdata;   // SW goes straight through
        case (req_in.op)
            SB: begin
                be_raw           = 4'b0001 << boff;
                steer.word       = '0;
                steer.lane[boff] = req_in.wdata[7:0];
            end
            SH: begin
                misalign                = boff[0];
                be_raw                  = 4'b0011 << boff;
                steer.word              = '0;
                steer.lane[boff]        = req_in.wdata[7:0];
                steer.lane[boff + 2'd1] = req_in.wdata[15:8];
            end
            SW:      begin misalign = |boff; be_raw = 4'b1111; end
            LH, LHU: misalign = boff[0];
            LW:      misalign = |boff;
            default: misalign = 1'b0;   // Byte loads fit anywhere
        endcase
    end

    // Outside RAM, upper half of the map, or misaligned
    assign bad = (offs >= 32'(`MEM_BYTES)) || req_in.addr[31] || misalign;

    always_ff @(posedge clock) begin
        if (!rst) cmd_valid <= 1'b0;
        else      cmd_valid <= in_valid;
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            cmd.idx    <= offs[`MEM_IDX_W+1:2];
            cmd.be     <= (is_store && !bad) ? be_raw : 4'b0000;
            cmd.rd     <= !is_store && !bad;
            cmd.wdata  <= steer;
            cmd.op     <= req_in.op;
            cmd.offset <= boff;
            cmd.err    <= bad;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mem_req_port.sv
// Data port front end
// Four-phase req/ack slave, one access in flight at a time
`timescale 1ns/1ns
`default_nettype none

module mem_req_port (
    input  wire                     clock,
    input  wire                     rst,
    input  wire                     req,
    input  wire mem_pkg::mem_op_e   op,
    input  wire [31:0]              addr,
    input  wire [31:0]              wdata,
    output logic                    ack,
    output logic [31:0]             rdata,
    output logic                    err,
    output logic                    req_valid,
    output mem_pkg::mem_req_t       req_out,
    input  wire                     rsp_valid,
    input  wire mem_pkg::mem_rsp_t  rsp_in
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,    // Waiting for req
        ST_BUSY,    // Access in the pipeline
        ST_HOLD     // ack high, waiting for req to drop
    } state_e;

    state_e   state;
    logic     accept;
    mem_rsp_t rsp_q;   // Response held for the master

    assign accept = (state == ST_IDLE) && req && !ack;

    always_ff @(posedge clock) begin
        if (!rst) begin
            state     <= ST_IDLE;
            ack       <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= accept;   // Single-cycle strobe
            case (state)
                ST_IDLE: if (accept) state <= ST_BUSY;
                ST_BUSY: if (rsp_valid) begin
                    ack   <= 1'b1;
                    state <= ST_HOLD;
                end
                ST_HOLD: if (!req) begin   // Master saw ack
                    ack   <= 1'b0;
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge clock) begin
        if (accept) begin
            req_out.op    <= op;
            req_out.addr  <= addr;
            req_out.wdata <= wdata;
        end
        if (state == ST_BUSY && rsp_valid) rsp_q <= rsp_in;
    end

    assign rdata = rsp_q.rdata;
    assign err   = rsp_q.err;

endmodule

`default_nettype wire

// File: hdl/mem_pkg.sv
// Memory subsystem types
// Access kinds, the lane-decoded word and the stage payloads
`default_nettype none

`include "mem_settings.svh"

package mem_pkg;

    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd3,
        LHU = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } mem_op_e;

    // One memory word, whole or by byte lane
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lane;   // lane[0] is the lowest address
    } mem_word_u;

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [`MEM_IDX_W-1:0] idx;      // Word index into the array
        logic [3:0]            be;       // Lane write enables
        logic                  rd;       // Load, read the word
        mem_word_u             wdata;    // Already steered to lanes
        mem_op_e               op;
        logic [1:0]            offset;   // Byte offset inside word
        logic                  err;
    } ram_cmd_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: hdl/mem_settings.svh
// Memory subsystem sizing
// RAM size, base address and word index width shared by package and RTL

`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// RAM size in bytes
`define MEM_BYTES 65536

// Bus address of byte 0
`define MEM_BASE 32'h0000_0000

// Word index width, log2(MEM_BYTES / 4)
`define MEM_IDX_W 14

`endif
